// File: core_pkg.sv
// shared widths, opcodes, reset vector, execute operations and the instruction views
`default_nettype none

package core_pkg;

	localparam int XLEN = 32;
	localparam int INST_W = 32;
	localparam int REG_AW = 5;
	localparam logic [XLEN-1:0] RESET_VEC = 32'h0000_0000;
	localparam int ISRAM_DEPTH = 256;

	// major opcodes
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL = 7'b1101111;

	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;

	typedef enum logic [2:0] {OP_NOP, OP_ADD, OP_BEQ, OP_BNE, OP_JAL} exu_op_e;

	// one fetched word, seen as I, B or J format
	typedef union packed {
		struct packed {
			logic [11:0] imm;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} i;
		struct packed {
			logic imm12;
			logic [5:0] imm10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm4_1;
			logic imm11;
			logic [6:0] opcode;
		} b;
		struct packed {
			logic imm20;
			logic [9:0] imm10_1;
			logic imm11;
			logic [7:0] imm19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j;
	} inst_u;

endpackage

`default_nettype wire

// File: ifu.sv
// instruction fetch unit with pc register, read channel fsm and allowin logic
`default_nettype none

module ifu (
	input logic clk,
	input logic rst,
	input logic run,
	input logic arready,
	input logic [core_pkg::INST_W-1:0] rdata,
	input logic rvalid,
	input logic [1:0] rresp,
	input logic redirect_valid,
	input logic redirect_taken,
	input logic [core_pkg::XLEN-1:0] redirect_target,
	input logic downstream_busy,
	output logic [core_pkg::XLEN-1:0] araddr,
	output logic arvalid,
	output logic rready,
	output logic fetch_valid,
	output logic [core_pkg::XLEN-1:0] fetch_pc,
	output logic [core_pkg::INST_W-1:0] fetch_inst
);
	import core_pkg::*;

	localparam logic [2:0] IDLE_R = 3'd0;
	localparam logic [2:0] WAIT_ARREADY = 3'd1;
	localparam logic [2:0] SHAKED_AR = 3'd2;
	localparam logic [2:0] WAIT_RVALID = 3'd3;
	localparam logic [2:0] SHAKED_R = 3'd4;

	logic [2:0] state;
	logic [2:0] next;
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] nextpc;
	logic pc_ok;
	logic allowin;
	logic start;

	// pc holds the last fetch address until execute reports the outcome
	assign nextpc = !redirect_valid ? pc :
		redirect_taken ? redirect_target : pc + XLEN'(4);

	// pc_ok low means the previous instruction has not resolved yet
	assign allowin = run && !downstream_busy && (pc_ok || redirect_valid);
	assign start = (state == IDLE_R || state == SHAKED_R) && allowin;

	always_comb begin
		next = IDLE_R;
		case (state)
			IDLE_R: next = allowin ? WAIT_ARREADY : IDLE_R;
			WAIT_ARREADY: next = arready ? SHAKED_AR : WAIT_ARREADY;
			SHAKED_AR: next = rvalid ? SHAKED_R : WAIT_RVALID;
			WAIT_RVALID: next = rvalid ? SHAKED_R : WAIT_RVALID;
			SHAKED_R: next = allowin ? WAIT_ARREADY : IDLE_R;
			default: next = IDLE_R;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE_R;
			pc <= RESET_VEC;
			pc_ok <= 1'b1;
		end else begin
			state <= next;
			if (redirect_valid)
				pc <= nextpc;
			if (start)
				pc_ok <= 1'b0;
			else if (redirect_valid)
				pc_ok <= 1'b1;
		end
	end

	// address is latched once per fetch and held through the handshake
	always_ff @(posedge clk) begin
		if (start)
			araddr <= nextpc;
	end

	assign arvalid = (state == WAIT_ARREADY);
	assign rready = (state == SHAKED_AR) || (state == WAIT_RVALID);
	assign fetch_valid = rready && rvalid;
	assign fetch_pc = araddr;
	assign fetch_inst = rdata;

	a_ar_hold: assert property (@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid && $stable(araddr));

	// the core only ever fetches from loaded memory
	a_rresp_ok: assert property (@(posedge clk) disable iff (rst)
		rvalid && rready |-> rresp == 2'b00);

endmodule

`default_nettype wire

// File: isram.sv
// instruction sram with load port and read channel of configurable latency
`default_nettype none

module isram #(
	parameter int ISRAM_LAT = 2
) (
	input logic clk,
	input logic rst,
	input logic load_en,
	input logic [$clog2(core_pkg::ISRAM_DEPTH)-1:0] load_addr,
	input logic [core_pkg::INST_W-1:0] load_data,
	input logic [core_pkg::XLEN-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [core_pkg::INST_W-1:0] rdata,
	output logic rvalid,
	output logic [1:0] rresp,
	input logic rready
);
	import core_pkg::*;

	localparam int AW = $clog2(ISRAM_DEPTH);
	localparam int CNT_W = $clog2(ISRAM_LAT + 1);

	logic [INST_W-1:0] mem [ISRAM_DEPTH];
	logic pending;
	logic [CNT_W-1:0] lat_cnt;
	logic ar_fire;
	logic r_fire;

	assign ar_fire = arvalid && arready;
	assign r_fire = rvalid && rready;
	assign rvalid = pending && (lat_cnt == '0);

	always_ff @(posedge clk) begin
		if (load_en)
			mem[load_addr] <= load_data;
	end

	// arready rises a cycle after a request shows up, never while a response waits
	always_ff @(posedge clk) begin
		if (rst) begin
			arready <= 1'b0;
			pending <= 1'b0;
			lat_cnt <= '0;
		end else begin
			arready <= arvalid && !arready && !pending;
			if (ar_fire) begin
				pending <= 1'b1;
				lat_cnt <= CNT_W'(ISRAM_LAT - 1);
			end else begin
				if (r_fire)
					pending <= 1'b0;
				if (pending && lat_cnt != '0)
					lat_cnt <= lat_cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ar_fire) begin
			rdata <= mem[araddr[AW+1:2]];
			rresp <= (araddr < XLEN'(ISRAM_DEPTH * 4)) ? 2'b00 : 2'b10;
		end
	end

	a_no_load_on_read: assert property (@(posedge clk) disable iff (rst)
		!(load_en && ar_fire));

endmodule

`default_nettype wire

// File: idu.sv
// decode unit with immediate assembly, operand read and one held instruction
`default_nettype none

module idu (
	input logic clk,
	input logic rst,
	input logic fetch_valid,
	input logic [core_pkg::XLEN-1:0] fetch_pc,
	input logic [core_pkg::INST_W-1:0] fetch_inst,
	input logic [core_pkg::XLEN-1:0] rs1_data,
	input logic [core_pkg::XLEN-1:0] rs2_data,
	output logic [core_pkg::REG_AW-1:0] rs1_addr,
	output logic [core_pkg::REG_AW-1:0] rs2_addr,
	output logic dec_valid,
	output core_pkg::exu_op_e dec_op,
	output logic [core_pkg::REG_AW-1:0] dec_rd,
	output logic [core_pkg::XLEN-1:0] dec_src1,
	output logic [core_pkg::XLEN-1:0] dec_src2,
	output logic [core_pkg::XLEN-1:0] dec_imm,
	output logic [core_pkg::XLEN-1:0] dec_pc,
	output logic busy
);
	import core_pkg::*;

	inst_u inst;
	exu_op_e op;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_j;
	logic [XLEN-1:0] imm;
	logic [XLEN-1:0] src2;

	assign inst = fetch_inst;
	assign rs1_addr = inst.i.rs1;
	assign rs2_addr = inst.b.rs2;

	assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
	assign imm_b = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
		inst.b.imm10_5, inst.b.imm4_1, 1'b0};
	assign imm_j = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
		inst.j.imm11, inst.j.imm10_1, 1'b0};

	always_comb begin
		op = OP_NOP;
		imm = imm_i;
		src2 = rs2_data;
		case (inst.i.opcode)
			OPC_OP_IMM: begin
				src2 = imm_i;
				if (inst.i.funct3 == F3_ADD)
					op = OP_ADD;
			end
			// funct7 of an R-type lands on the B immediate's upper bits
			OPC_OP: begin
				if (inst.i.funct3 == F3_ADD && {inst.b.imm12, inst.b.imm10_5} == 7'd0)
					op = OP_ADD;
			end
			OPC_BRANCH: begin
				imm = imm_b;
				if (inst.b.funct3 == F3_BEQ)
					op = OP_BEQ;
				else if (inst.b.funct3 == F3_BNE)
					op = OP_BNE;
			end
			OPC_JAL: begin
				imm = imm_j;
				op = OP_JAL;
			end
			default: op = OP_NOP;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			dec_valid <= 1'b0;
		else
			dec_valid <= fetch_valid;
	end

	always_ff @(posedge clk) begin
		if (fetch_valid) begin
			dec_op <= op;
			dec_rd <= inst.i.rd;
			dec_src1 <= rs1_data;
			dec_src2 <= src2;
			dec_imm <= imm;
			dec_pc <= fetch_pc;
		end
	end

	assign busy = dec_valid;

endmodule

`default_nettype wire

// File: regfile.sv
// 32 entry register file, two async read ports, one sync write port, x0 fixed at zero
`default_nettype none

module regfile (
	input logic clk,
	input logic rst,
	input logic [core_pkg::REG_AW-1:0] rs1_addr,
	input logic [core_pkg::REG_AW-1:0] rs2_addr,
	input logic wen,
	input logic [core_pkg::REG_AW-1:0] waddr,
	input logic [core_pkg::XLEN-1:0] wdata,
	output logic [core_pkg::XLEN-1:0] rs1_data,
	output logic [core_pkg::XLEN-1:0] rs2_data
);
	import core_pkg::*;

	logic [XLEN-1:0] regs [2**REG_AW];

	// architectural state starts from all zeros
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < 2**REG_AW; k++)
				regs[k] <= '0;
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// File: exu.sv
// execute unit with add, branch compare, jal link, next pc, writeback and retire report
`default_nettype none

module exu (
	input logic clk,
	input logic rst,
	input logic dec_valid,
	input core_pkg::exu_op_e dec_op,
	input logic [core_pkg::REG_AW-1:0] dec_rd,
	input logic [core_pkg::XLEN-1:0] dec_src1,
	input logic [core_pkg::XLEN-1:0] dec_src2,
	input logic [core_pkg::XLEN-1:0] dec_imm,
	input logic [core_pkg::XLEN-1:0] dec_pc,
	output logic wen,
	output logic [core_pkg::REG_AW-1:0] waddr,
	output logic [core_pkg::XLEN-1:0] wdata,
	output logic redirect_valid,
	output logic redirect_taken,
	output logic [core_pkg::XLEN-1:0] redirect_target,
	output logic retire_valid,
	output logic [core_pkg::XLEN-1:0] retire_pc,
	output logic [core_pkg::REG_AW-1:0] retire_rd,
	output logic [core_pkg::XLEN-1:0] retire_wdata,
	output logic retire_wen,
	output logic busy
);
	import core_pkg::*;

	logic src_eq;
	logic writes;
	logic taken;
	logic [XLEN-1:0] result;

	assign src_eq = (dec_src1 == dec_src2);

	always_comb begin
		writes = 1'b0;
		taken = 1'b0;
		result = dec_src1 + dec_src2;
		case (dec_op)
			OP_ADD: writes = 1'b1;
			OP_JAL: begin
				writes = 1'b1;
				taken = 1'b1;
				result = dec_pc + XLEN'(4);
			end
			OP_BEQ: taken = src_eq;
			OP_BNE: taken = !src_eq;
			default: writes = 1'b0;
		endcase
	end

	// x0 as destination counts as no write
	assign wen = dec_valid && writes && (dec_rd != '0);
	assign waddr = dec_rd;
	assign wdata = result;
	assign busy = dec_valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			retire_valid <= 1'b0;
			redirect_valid <= 1'b0;
			retire_wen <= 1'b0;
		end else begin
			retire_valid <= dec_valid;
			redirect_valid <= dec_valid;
			retire_wen <= wen;
		end
	end

	always_ff @(posedge clk) begin
		if (dec_valid) begin
			redirect_taken <= taken;
			redirect_target <= dec_pc + dec_imm;
			retire_pc <= dec_pc;
			retire_rd <= dec_rd;
			retire_wdata <= result;
		end
	end

	// one instruction in flight keeps the redirect a single cycle pulse
	a_redirect_pulse: assert property (@(posedge clk) disable iff (rst)
		redirect_valid |=> !redirect_valid);

endmodule

`default_nettype wire

// File: fetch_core.sv
// top level connecting fetch, instruction sram, decode, register file and execute
`default_nettype none

module fetch_core #(
	parameter int ISRAM_LAT = 2
) (
	input logic clk,
	input logic rst,
	input logic run,
	input logic load_en,
	input logic [$clog2(core_pkg::ISRAM_DEPTH)-1:0] load_addr,
	input logic [core_pkg::INST_W-1:0] load_data,
	output logic retire_valid,
	output logic [core_pkg::XLEN-1:0] retire_pc,
	output logic retire_wen,
	output logic [core_pkg::REG_AW-1:0] retire_rd,
	output logic [core_pkg::XLEN-1:0] retire_wdata
);
	import core_pkg::*;

	logic [XLEN-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [INST_W-1:0] rdata;
	logic rvalid;
	logic [1:0] rresp;
	logic rready;
	logic fetch_valid;
	logic [XLEN-1:0] fetch_pc;
	logic [INST_W-1:0] fetch_inst;
	logic [REG_AW-1:0] rs1_addr;
	logic [REG_AW-1:0] rs2_addr;
	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;
	logic dec_valid;
	exu_op_e dec_op;
	logic [REG_AW-1:0] dec_rd;
	logic [XLEN-1:0] dec_src1;
	logic [XLEN-1:0] dec_src2;
	logic [XLEN-1:0] dec_imm;
	logic [XLEN-1:0] dec_pc;
	logic wen;
	logic [REG_AW-1:0] waddr;
	logic [XLEN-1:0] wdata;
	logic redirect_valid;
	logic redirect_taken;
	logic [XLEN-1:0] redirect_target;
	logic idu_busy;
	logic exu_busy;

	ifu u_ifu (
		.clk(clk), .rst(rst), .run(run),
		.arready(arready), .rdata(rdata), .rvalid(rvalid), .rresp(rresp),
		.redirect_valid(redirect_valid), .redirect_taken(redirect_taken),
		.redirect_target(redirect_target), .downstream_busy(idu_busy || exu_busy),
		.araddr(araddr), .arvalid(arvalid), .rready(rready),
		.fetch_valid(fetch_valid), .fetch_pc(fetch_pc), .fetch_inst(fetch_inst)
	);

	isram #(.ISRAM_LAT(ISRAM_LAT)) u_isram (
		.clk(clk), .rst(rst),
		.load_en(load_en), .load_addr(load_addr), .load_data(load_data),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rvalid(rvalid), .rresp(rresp), .rready(rready)
	);

	idu u_idu (
		.clk(clk), .rst(rst),
		.fetch_valid(fetch_valid), .fetch_pc(fetch_pc), .fetch_inst(fetch_inst),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.dec_valid(dec_valid), .dec_op(dec_op), .dec_rd(dec_rd),
		.dec_src1(dec_src1), .dec_src2(dec_src2), .dec_imm(dec_imm),
		.dec_pc(dec_pc), .busy(idu_busy)
	);

	regfile u_regfile (
		.clk(clk), .rst(rst),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.wen(wen), .waddr(waddr), .wdata(wdata),
		.rs1_data(rs1_data), .rs2_data(rs2_data)
	);

	exu u_exu (
		.clk(clk), .rst(rst),
		.dec_valid(dec_valid), .dec_op(dec_op), .dec_rd(dec_rd),
		.dec_src1(dec_src1), .dec_src2(dec_src2), .dec_imm(dec_imm), .dec_pc(dec_pc),
		.wen(wen), .waddr(waddr), .wdata(wdata),
		.redirect_valid(redirect_valid), .redirect_taken(redirect_taken),
		.redirect_target(redirect_target),
		.retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
		.retire_wdata(retire_wdata), .retire_wen(retire_wen), .busy(exu_busy)
	);

endmodule

`default_nettype wire

// File: tb_fetch_core.sv
// testbench for fetch_core with program builder, loader, reference model and retire checks
`default_nettype none

module tb_fetch_core;
	import core_pkg::*;

	localparam int AW = $clog2(ISRAM_DEPTH);
	localparam int RETIRE_TIMEOUT = 64;
	localparam int MAX_RETIRES = 1000;

	logic clk;
	logic rst;
	logic run;
	logic load_en;
	logic [AW-1:0] load_addr;
	logic [INST_W-1:0] load_data;
	logic retire_valid;
	logic [XLEN-1:0] retire_pc;
	logic retire_wen;
	logic [REG_AW-1:0] retire_rd;
	logic [XLEN-1:0] retire_wdata;

	logic [INST_W-1:0] prog [ISRAM_DEPTH];
	int prog_len;
	logic [XLEN-1:0] halt_pc;
	logic [XLEN-1:0] m_pc;
	logic [XLEN-1:0] m_regs [2**REG_AW];
	logic [31:0] seed;
	logic checking;
	logic done;
	int retire_count;
	logic [XLEN-1:0] e_pc;
	logic e_wen;
	logic [REG_AW-1:0] e_rd;
	logic [XLEN-1:0] e_wdata;

	fetch_core #(.ISRAM_LAT(3)) u_dut (
		.clk(clk), .rst(rst), .run(run),
		.load_en(load_en), .load_addr(load_addr), .load_data(load_data),
		.retire_valid(retire_valid), .retire_pc(retire_pc), .retire_wen(retire_wen),
		.retire_rd(retire_rd), .retire_wdata(retire_wdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// one encoder per instruction format
	function automatic logic [31:0] addi_word(input logic [31:0] rd, rs1, imm);
		return {imm[11:0], rs1[4:0], F3_ADD, rd[4:0], OPC_OP_IMM};
	endfunction

	function automatic logic [31:0] add_word(input logic [31:0] rd, rs1, rs2);
		return {7'd0, rs2[4:0], rs1[4:0], F3_ADD, rd[4:0], OPC_OP};
	endfunction

	function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [31:0] rs1,
		rs2, off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] jal_word(input logic [31:0] rd, off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
	endfunction

	// architectural model stepped by one instruction per call
	function automatic void model_step(output logic [XLEN-1:0] pc_o, output logic wen_o,
		output logic [REG_AW-1:0] rd_o, output logic [XLEN-1:0] wdata_o);
		logic [31:0] w;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] npc;
		logic wr;
		w = prog[m_pc[AW+1:2]];
		a = m_regs[w[19:15]];
		b = m_regs[w[24:20]];
		npc = m_pc + 32'd4;
		wr = 1'b0;
		wdata_o = '0;
		if (w[6:0] == OPC_OP_IMM && w[14:12] == 3'b000) begin
			wr = 1'b1;
			wdata_o = a + {{20{w[31]}}, w[31:20]};
		end else if (w[6:0] == OPC_OP && w[14:12] == 3'b000 && w[31:25] == 7'd0) begin
			wr = 1'b1;
			wdata_o = a + b;
		end else if (w[6:0] == OPC_BRANCH) begin
			if ((w[14:12] == 3'b000 && a == b) || (w[14:12] == 3'b001 && a != b))
				npc = m_pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		end else if (w[6:0] == OPC_JAL) begin
			wr = 1'b1;
			wdata_o = m_pc + 32'd4;
			npc = m_pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		end
		pc_o = m_pc;
		rd_o = w[11:7];
		wen_o = wr && (w[11:7] != 5'd0);
		if (wen_o)
			m_regs[w[11:7]] = wdata_o;
		m_pc = npc;
	endfunction

	task automatic stop_with_failure();
		$display("SOME TESTS FAILED");
		$fatal(1, "test stopped at first error");
	endtask

	task automatic compare_word(input string field, input logic [XLEN-1:0] got, exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, field, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_index(input string field, input logic [REG_AW-1:0] got, exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, field, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic verify_flag(input string field, input logic got, exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %b expected %b", $time, field, got, exp);
			stop_with_failure();
		end
	endtask

	// monitor compares every retire against the model
	always @(posedge clk) begin
		if (checking && !done && retire_valid) begin
			model_step(e_pc, e_wen, e_rd, e_wdata);
			compare_word("retire_pc", retire_pc, e_pc);
			verify_flag("retire_wen", retire_wen, e_wen);
			check_index("retire_rd", retire_rd, e_rd);
			if (e_wen)
				compare_word("retire_wdata", retire_wdata, e_wdata);
			retire_count <= retire_count + 1;
			if (e_pc == halt_pc)
				done <= 1'b1;
		end
	end

	task automatic append_inst(input logic [31:0] w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	// appends the self loop then resets, loads and runs until the model reaches it
	task automatic run_program();
		int seen;
		int idle;
		append_inst(jal_word(0, 0));
		halt_pc = (prog_len - 1) * 4;
		@(posedge clk);
		rst <= 1'b1;
		run <= 1'b0;
		checking <= 1'b0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		for (int k = 0; k < prog_len; k++) begin
			@(posedge clk);
			load_en <= 1'b1;
			load_addr <= k;
			load_data <= prog[k];
		end
		@(posedge clk);
		load_en <= 1'b0;
		m_pc = RESET_VEC;
		for (int k = 0; k < 2**REG_AW; k++)
			m_regs[k] = '0;
		done <= 1'b0;
		retire_count <= 0;
		checking <= 1'b1;
		run <= 1'b1;
		seen = 0;
		idle = 0;
		@(posedge clk);
		while (!done) begin
			@(posedge clk);
			if (retire_count != seen) begin
				seen = retire_count;
				idle = 0;
			end else begin
				idle++;
			end
			if (idle > RETIRE_TIMEOUT) begin
				$display("Timeout at %0t: core stopped retiring before the halt loop", $time);
				stop_with_failure();
			end
			if (seen > MAX_RETIRES) begin
				$display("Error at %0t: halt loop not reached within %0d retires",
					$time, MAX_RETIRES);
				stop_with_failure();
			end
		end
		run <= 1'b0;
		checking <= 1'b0;
		prog_len = 0;
	endtask

	// mixed program whose branches and jumps only go forward up to the halt word
	task automatic build_random_program(input int count);
		logic [31:0] r;
		logic [31:0] off;
		for (int i = 0; i < count; i++) begin
			r = $random(seed);
			off = 4 * (1 + (r[30:20] % (count - i)));
			case (r[2:0])
				0, 1, 2: append_inst(addi_word(r[5:3], r[8:6], r[31:20]));
				3, 4: append_inst(add_word(r[5:3], r[8:6], r[11:9]));
				5: append_inst(branch_word(r[12] ? F3_BNE : F3_BEQ, r[8:6], r[11:9], off));
				6: append_inst(jal_word(r[5:3], off));
				default: append_inst({r[31:7], 7'h0b});
			endcase
		end
	endtask

	initial begin
		rst = 1'b1;
		run = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		checking = 1'b0;
		done = 1'b0;
		retire_count = 0;
		prog_len = 0;
		seed = 32'h6ecb82a3;

		// addi chain
		append_inst(addi_word(1, 0, 5));
		append_inst(addi_word(2, 1, -3));
		append_inst(addi_word(1, 1, 100));
		append_inst(addi_word(3, 2, 2047));
		append_inst(addi_word(4, 3, -2048));
		run_program();

		// add after addi and x0 as destination
		append_inst(addi_word(5, 0, 7));
		append_inst(addi_word(6, 0, -9));
		append_inst(add_word(7, 5, 6));
		append_inst(add_word(0, 5, 6));
		append_inst(addi_word(0, 0, 1));
		append_inst(add_word(8, 0, 0));
		append_inst(add_word(9, 7, 5));
		run_program();

		// counted loop with a backward bne, then taken and not taken branches
		append_inst(addi_word(1, 0, 3));
		append_inst(addi_word(2, 2, 1));
		append_inst(addi_word(1, 1, -1));
		append_inst(branch_word(F3_BNE, 1, 0, -8));
		append_inst(branch_word(F3_BEQ, 1, 0, 8));
		append_inst(addi_word(3, 0, 99));
		append_inst(branch_word(F3_BEQ, 2, 1, 8));
		append_inst(branch_word(F3_BNE, 1, 0, 8));
		run_program();

		// jal link and unknown opcodes
		append_inst(jal_word(1, 12));
		append_inst(32'h1234_5677);
		append_inst(32'h0000_0000);
		append_inst(32'h0000_7fff);
		append_inst(jal_word(0, 8));
		append_inst(32'hdead_beef);
		append_inst(addi_word(2, 1, 0));
		run_program();

		build_random_program(60);
		run_program();

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: fetch_core.f
core_pkg.sv
ifu.sv
isram.sv
idu.sv
regfile.sv
exu.sv
fetch_core.sv
tb_fetch_core.sv

// File: Bender.yml
package:
  name: fetch_core

sources:
  - core_pkg.sv
  - ifu.sv
  - isram.sv
  - idu.sv
  - regfile.sv
  - exu.sv
  - fetch_core.sv
  - target: test
    files:
      - tb_fetch_core.sv
